//--- build.f
+incdir+logic
logic/csr_pkg.sv
logic/csr_req_queue.sv
logic/csr_regfile.sv
logic/csr_exec.sv
logic/csr_unit.sv
sim/csr_unit_properties.sv
sim/csr_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module csr_unit_tb -f build.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vcsr_unit_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run passes only if the testbench printed its pass line.
if grep -qx "No errors" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

//--- sim/csr_unit_tb.sv
`include "csr_cfg.svh"

module csr_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    localparam int WAIT_LIMIT = 50;

    logic        clock;
    logic        reset;
    logic        req_valid_i;
    csr_op_t     req_op_i;
    logic [11:0] req_addr_i;
    logic [31:0] req_wdata_i;
    logic [31:0] req_pc_i;
    logic        req_credit_o;
    logic        rsp_credit_i;
    logic        rsp_valid_o;
    logic [31:0] rsp_rdata_o;
    logic        rsp_illegal_o;
    logic        rsp_redirect_o;
    logic [31:0] rsp_target_o;

    int          errors = 0;
    int          req_credits = `REQ_DEPTH;
    int          credits_seen = 0;
    int          owed_credits = 0;
    int          rsp_seen = 0;
    bit          hold_credits = 1'b0;
    logic [15:0] lfsr_state = 16'd62044;

    // reference copies of the writable machine registers.
    logic [31:0] m_mstatus = '0;
    logic [31:0] m_mtvec = '0;
    logic [31:0] m_mepc = '0;
    logic [31:0] m_mcause = '0;

    // each entry holds {illegal, redirect, target, rdata}.
    logic [65:0] responses [$];
    logic [65:0] expected [$];

    csr_unit i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(negedge clock) begin
        if (!reset && rsp_valid_o) begin
            responses.push_back({rsp_illegal_o, rsp_redirect_o, rsp_target_o, rsp_rdata_o});
            rsp_seen++;
            owed_credits++;
        end
        if (!reset && req_credit_o) begin
            req_credits++;
            credits_seen++;
        end
    end

    // the core hands back one response credit per consumed response.
    initial begin
        rsp_credit_i = 1'b0;
        forever begin
            @(posedge clock);
            #2;
            if (!hold_credits && owed_credits > 0) begin
                rsp_credit_i = 1'b1;
                owed_credits--;
            end else begin
                rsp_credit_i = 1'b0;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s expected 0x%08h got 0x%08h", name, exp, got);
        end
    endtask

    function automatic logic [31:0] random_word();
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            word = {word[30:0], lfsr_state[0]};
        end
        return word;
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            `CSR_MSTATUS:   return m_mstatus;
            `CSR_MTVEC:     return m_mtvec;
            `CSR_MEPC:      return m_mepc;
            `CSR_MCAUSE:    return m_mcause;
            `CSR_MVENDORID: return `CSR_VENDOR_ID;
            `CSR_MARCHID:   return `CSR_ARCH_ID;
            default:        return '0;
        endcase
    endfunction

    task automatic predict_response(input csr_op_t op, input logic [11:0] addr,
                                    input logic [31:0] wdata, input logic [31:0] pc);
        logic [31:0] old;
        logic [31:0] value;
        logic        known;
        logic        read_only;
        logic        illegal;
        old = model_read(addr);
        read_only = (addr == `CSR_MVENDORID) || (addr == `CSR_MARCHID);
        known = read_only || (addr == `CSR_MSTATUS) || (addr == `CSR_MTVEC) ||
                (addr == `CSR_MEPC) || (addr == `CSR_MCAUSE);
        if (op == CSR_ECALL) begin
            expected.push_back({1'b0, 1'b1, m_mtvec, 32'h0});
            m_mepc = pc;
            m_mcause = `ECALL_CAUSE;
            m_mstatus[MSTATUS_MPIE] = m_mstatus[MSTATUS_MIE];
            m_mstatus[MSTATUS_MIE] = 1'b0;
        end else if (op == CSR_MRET) begin
            expected.push_back({1'b0, 1'b1, m_mepc, 32'h0});
            m_mstatus[MSTATUS_MIE] = m_mstatus[MSTATUS_MPIE];
            m_mstatus[MSTATUS_MPIE] = 1'b1;
        end else begin
            // set or clear with a zero mask is a plain read.
            illegal = !known || (read_only && (op == CSR_RW || wdata != '0));
            expected.push_back({illegal, 1'b0, 32'h0, illegal ? 32'h0 : old});
            case (op)
                CSR_RS:  value = old | wdata;
                CSR_RC:  value = old & ~wdata;
                default: value = wdata;
            endcase
            if (!illegal) begin
                case (addr)
                    `CSR_MSTATUS: m_mstatus = value;
                    `CSR_MTVEC:   m_mtvec = {value[31:2], 2'b00};
                    `CSR_MEPC:    m_mepc = value;
                    `CSR_MCAUSE:  m_mcause = value;
                    default:      m_mcause = m_mcause;
                endcase
            end
        end
    endtask

    task automatic send_request(input csr_op_t op, input logic [11:0] addr,
                                input logic [31:0] wdata, input logic [31:0] pc);
        int waited;
        waited = 0;
        while (req_credits == 0 && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (req_credits == 0) begin
            errors++;
            $display("no request credit came back, request dropped");
        end else begin
            predict_response(op, addr, wdata, pc);
            req_credits--;
            req_valid_i = 1'b1;
            req_op_i = op;
            req_addr_i = addr;
            req_wdata_i = wdata;
            req_pc_i = pc;
            next_cycle();
            req_valid_i = 1'b0;
        end
    endtask

    task automatic collect_response();
        logic [65:0] got;
        logic [65:0] exp;
        int          waited;
        waited = 0;
        while (responses.size() == 0 && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        exp = expected.pop_front();
        if (responses.size() == 0) begin
            errors++;
            $display("a response never arrived");
        end else begin
            got = responses.pop_front();
            check_value("rsp_rdata_o", got[31:0], exp[31:0]);
            check_value("rsp_illegal_o", 32'(got[65]), 32'(exp[65]));
            check_value("rsp_redirect_o", 32'(got[64]), 32'(exp[64]));
            if (exp[64]) begin
                check_value("rsp_target_o", got[63:32], exp[63:32]);
            end
        end
    endtask

    task automatic drain_responses();
        while (expected.size() > 0) begin
            collect_response();
        end
    endtask

    task automatic issue(input csr_op_t op, input logic [11:0] addr,
                         input logic [31:0] wdata, input logic [31:0] pc);
        send_request(op, addr, wdata, pc);
        drain_responses();
    endtask

    task automatic read_csr(input logic [11:0] addr);
        issue(CSR_RS, addr, 32'h0, 32'h0);
    endtask

    task automatic read_all_csrs();
        read_csr(`CSR_MSTATUS);
        read_csr(`CSR_MTVEC);
        read_csr(`CSR_MEPC);
        read_csr(`CSR_MCAUSE);
        read_csr(`CSR_MVENDORID);
        read_csr(`CSR_MARCHID);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((req_credits != `REQ_DEPTH || owed_credits != 0) && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (req_credits != `REQ_DEPTH || owed_credits != 0) begin
            errors++;
            $display("credits did not settle after the last response");
        end
    endtask

    task automatic rmw_sequence(input logic [11:0] addr);
        issue(CSR_RW, addr, random_word() | 32'h3, 32'h0);
        read_csr(addr);
        issue(CSR_RS, addr, random_word(), 32'h0);
        read_csr(addr);
        issue(CSR_RC, addr, random_word(), 32'h0);
        read_csr(addr);
    endtask

    task automatic trap_entry_and_return();
        // MIE set and MPIE clear, so both trap copies are visible.
        issue(CSR_RW, `CSR_MSTATUS,
              (random_word() | (32'h1 << MSTATUS_MIE)) & ~(32'h1 << MSTATUS_MPIE), 32'h0);
        issue(CSR_RW, `CSR_MTVEC, random_word(), 32'h0);
        issue(CSR_ECALL, 12'h000, 32'h0, random_word());
        read_all_csrs();
        issue(CSR_MRET, 12'h000, 32'h0, 32'h0);
        read_all_csrs();
        // with MIE set and MPIE clear, mret must clear MIE and set MPIE.
        issue(CSR_RC, `CSR_MSTATUS, 32'h1 << MSTATUS_MPIE, 32'h0);
        issue(CSR_MRET, 12'h000, 32'h0, 32'h0);
        read_all_csrs();
    endtask

    task automatic illegal_accesses();
        read_csr(12'h7C0);
        issue(CSR_RW, `CSR_MARCHID, random_word(), 32'h0);
        read_all_csrs();
    endtask

    task automatic credit_backpressure();
        int base;
        int waited;
        wait_idle();
        hold_credits = 1'b1;
        base = rsp_seen;
        credits_seen = 0;
        send_request(CSR_RW, `CSR_MEPC, random_word(), 32'h0);
        send_request(CSR_RS, `CSR_MCAUSE, random_word(), 32'h0);
        send_request(CSR_RC, `CSR_MEPC, random_word(), 32'h0);
        send_request(CSR_RS, `CSR_MEPC, 32'h0, 32'h0);
        waited = 0;
        while (rsp_seen - base < `RSP_CREDITS && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        // any response beyond the granted credits would show up here.
        repeat (8) next_cycle();
        check_value("rsp_valid_o count", 32'(rsp_seen - base), 32'(`RSP_CREDITS));
        if (credits_seen > `RSP_CREDITS) begin
            errors++;
            $display("more request credits came back than responses were allowed");
        end
        hold_credits = 1'b0;
        drain_responses();
        wait_idle();
        check_value("req_credit_o count", 32'(req_credits), 32'(`REQ_DEPTH));
    endtask

    initial begin
        reset = 1'b1;
        req_valid_i = 1'b0;
        req_op_i = CSR_RW;
        req_addr_i = '0;
        req_wdata_i = '0;
        req_pc_i = '0;
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;
        read_all_csrs();
        rmw_sequence(`CSR_MSTATUS);
        rmw_sequence(`CSR_MEPC);
        rmw_sequence(`CSR_MCAUSE);
        rmw_sequence(`CSR_MTVEC);
        trap_entry_and_return();
        illegal_accesses();
        credit_backpressure();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- sim/csr_unit_properties.sv
`include "csr_cfg.svh"

module csr_unit_properties (
    input logic clock,
    input logic reset,
    input logic rsp_valid_i,
    input logic rsp_illegal_i,
    input logic rsp_redirect_i,
    input logic req_credit_i,
    input logic rsp_credit_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // responses issued whose credit the core has not yet returned.
    int outstanding;

    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(rsp_valid_i) - int'(rsp_credit_i);
        end
    end

    a_redirect_valid: assert property (@(posedge clock) disable iff (reset)
        rsp_redirect_i |-> rsp_valid_i)
        else $error("rsp_redirect_o high without rsp_valid_o");

    a_illegal_valid: assert property (@(posedge clock) disable iff (reset)
        rsp_illegal_i |-> rsp_valid_i)
        else $error("rsp_illegal_o high without rsp_valid_o");

    a_redirect_or_illegal: assert property (@(posedge clock) disable iff (reset)
        !(rsp_redirect_i && rsp_illegal_i))
        else $error("rsp_redirect_o and rsp_illegal_o high together");

    a_quiet_after_reset: assert property (@(posedge clock)
        reset |=> !rsp_valid_i && !rsp_redirect_i && !rsp_illegal_i && !req_credit_i)
        else $error("outputs not low in the cycle after reset");

    a_outstanding_limit: assert property (@(posedge clock) disable iff (reset)
        outstanding <= `RSP_CREDITS)
        else $error("more responses outstanding than response credits");

endmodule

bind csr_unit csr_unit_properties i_properties (
    .clock          (clock),
    .reset          (reset),
    .rsp_valid_i    (rsp_valid_o),
    .rsp_illegal_i  (rsp_illegal_o),
    .rsp_redirect_i (rsp_redirect_o),
    .req_credit_i   (req_credit_o),
    .rsp_credit_i   (rsp_credit_i)
);

//--- logic/csr_unit.sv
module csr_unit (
    input  logic             clock,
    input  logic             reset,
    input  logic             req_valid_i,
    input  csr_pkg::csr_op_t req_op_i,
    input  logic [11:0]      req_addr_i,
    input  logic [31:0]      req_wdata_i,
    input  logic [31:0]      req_pc_i,
    output logic             req_credit_o,
    input  logic             rsp_credit_i,
    output logic             rsp_valid_o,
    output logic [31:0]      rsp_rdata_o,
    output logic             rsp_illegal_o,
    output logic             rsp_redirect_o,
    output logic [31:0]      rsp_target_o
);
    import csr_pkg::*;

    logic        q_valid;
    csr_op_t     q_op;
    logic [11:0] q_addr;
    logic [31:0] q_wdata;
    logic [31:0] q_pc;
    logic        q_pop;

    logic [11:0] rd_addr;
    logic [31:0] rd_data;
    logic        rd_known;
    logic        rd_writable;
    logic        wr_en;
    logic [11:0] wr_addr;
    logic [31:0] wr_data;
    logic        trap;
    logic [31:0] trap_pc;
    logic        mret;
    logic [31:0] mtvec;
    logic [31:0] mepc;

    csr_req_queue i_queue (
        .clock       (clock),
        .reset       (reset),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_pc_i    (req_pc_i),
        .pop_i       (q_pop),
        .valid_o     (q_valid),
        .op_o        (q_op),
        .addr_o      (q_addr),
        .wdata_o     (q_wdata),
        .pc_o        (q_pc),
        .credit_o    (req_credit_o)
    );

    csr_exec i_exec (
        .clock          (clock),
        .reset          (reset),
        .q_valid_i      (q_valid),
        .q_op_i         (q_op),
        .q_addr_i       (q_addr),
        .q_wdata_i      (q_wdata),
        .q_pc_i         (q_pc),
        .q_pop_o        (q_pop),
        .rd_addr_o      (rd_addr),
        .rd_data_i      (rd_data),
        .rd_known_i     (rd_known),
        .rd_writable_i  (rd_writable),
        .wr_en_o        (wr_en),
        .wr_addr_o      (wr_addr),
        .wr_data_o      (wr_data),
        .trap_o         (trap),
        .trap_pc_o      (trap_pc),
        .mret_o         (mret),
        .mtvec_i        (mtvec),
        .mepc_i         (mepc),
        .rsp_credit_i   (rsp_credit_i),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_rdata_o    (rsp_rdata_o),
        .rsp_illegal_o  (rsp_illegal_o),
        .rsp_redirect_o (rsp_redirect_o),
        .rsp_target_o   (rsp_target_o)
    );

    csr_regfile i_regfile (
        .clock         (clock),
        .reset         (reset),
        .rd_addr_i     (rd_addr),
        .rd_data_o     (rd_data),
        .rd_known_o    (rd_known),
        .rd_writable_o (rd_writable),
        .wr_en_i       (wr_en),
        .wr_addr_i     (wr_addr),
        .wr_data_i     (wr_data),
        .trap_i        (trap),
        .trap_pc_i     (trap_pc),
        .mret_i        (mret),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc)
    );

endmodule

//--- logic/csr_exec.sv
`include "csr_cfg.svh"

module csr_exec (
    input  logic             clock,
    input  logic             reset,
    input  logic             q_valid_i,
    input  csr_pkg::csr_op_t q_op_i,
    input  logic [11:0]      q_addr_i,
    input  logic [31:0]      q_wdata_i,
    input  logic [31:0]      q_pc_i,
    output logic             q_pop_o,
    output logic [11:0]      rd_addr_o,
    input  logic [31:0]      rd_data_i,
    input  logic             rd_known_i,
    input  logic             rd_writable_i,
    output logic             wr_en_o,
    output logic [11:0]      wr_addr_o,
    output logic [31:0]      wr_data_o,
    output logic             trap_o,
    output logic [31:0]      trap_pc_o,
    output logic             mret_o,
    input  logic [31:0]      mtvec_i,
    input  logic [31:0]      mepc_i,
    input  logic             rsp_credit_i,
    output logic             rsp_valid_o,
    output logic [31:0]      rsp_rdata_o,
    output logic             rsp_illegal_o,
    output logic             rsp_redirect_o,
    output logic [31:0]      rsp_target_o
);
    import csr_pkg::*;

    localparam int CW = $clog2(`RSP_CREDITS + 1);

    logic [CW-1:0] rsp_credits;
    logic          start;
    logic          is_csr;
    logic          is_ecall;
    logic          is_mret;
    logic          modifies;
    logic          illegal;
    logic [31:0]   new_value;

    assign start    = q_valid_i && (rsp_credits != '0);
    assign is_csr   = (q_op_i == CSR_RW) || (q_op_i == CSR_RS) || (q_op_i == CSR_RC);
    assign is_ecall = (q_op_i == CSR_ECALL);
    assign is_mret  = (q_op_i == CSR_MRET);

    // set or clear with a zero mask leaves the register as it is,
    // so that form is how the core reads a read-only register.
    assign modifies = (q_op_i == CSR_RW) || (q_wdata_i != '0);

    always_comb begin
        if (is_csr) begin
            illegal = !rd_known_i || (modifies && !rd_writable_i);
        end else begin
            illegal = !(is_ecall || is_mret);
        end
    end

    always_comb begin
        case (q_op_i)
            CSR_RS:  new_value = rd_data_i | q_wdata_i;
            CSR_RC:  new_value = rd_data_i & ~q_wdata_i;
            default: new_value = q_wdata_i;
        endcase
    end

    assign q_pop_o   = start;
    assign rd_addr_o = q_addr_i;
    assign wr_addr_o = q_addr_i;
    assign wr_data_o = new_value;
    assign wr_en_o   = start && is_csr && rd_known_i && rd_writable_i;
    assign trap_o    = start && is_ecall;
    assign trap_pc_o = q_pc_i;
    assign mret_o    = start && is_mret;

    always_ff @(posedge clock) begin
        if (reset) begin
            rsp_credits <= CW'(`RSP_CREDITS);
        end else begin
            case ({start, rsp_credit_i})
                2'b10:   rsp_credits <= rsp_credits - 1'b1;
                2'b01:   rsp_credits <= rsp_credits + 1'b1;
                default: rsp_credits <= rsp_credits;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rsp_valid_o    <= 1'b0;
            rsp_illegal_o  <= 1'b0;
            rsp_redirect_o <= 1'b0;
        end else begin
            rsp_valid_o    <= start;
            rsp_illegal_o  <= start && illegal;
            rsp_redirect_o <= start && (is_ecall || is_mret);
        end
    end

    // the response payload is only meaningful while rsp_valid_o is high.
    always_ff @(posedge clock) begin
        if (start) begin
            rsp_rdata_o  <= (is_csr && !illegal) ? rd_data_i : '0;
            rsp_target_o <= is_ecall ? mtvec_i : mepc_i;
        end
    end

endmodule

//--- logic/csr_regfile.sv
`include "csr_cfg.svh"

module csr_regfile (
    input  logic        clock,
    input  logic        reset,
    input  logic [11:0] rd_addr_i,
    output logic [31:0] rd_data_o,
    output logic        rd_known_o,
    output logic        rd_writable_o,
    input  logic        wr_en_i,
    input  logic [11:0] wr_addr_i,
    input  logic [31:0] wr_data_i,
    input  logic        trap_i,
    input  logic [31:0] trap_pc_i,
    input  logic        mret_i,
    output logic [31:0] mtvec_o,
    output logic [31:0] mepc_o
);
    import csr_pkg::*;

    logic [31:0] mstatus;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] mcause;

    always_ff @(posedge clock) begin
        if (reset) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (trap_i) begin
            mepc                  <= trap_pc_i;
            mcause                <= `ECALL_CAUSE;
            mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
            mstatus[MSTATUS_MIE]  <= 1'b0;
        end else if (mret_i) begin
            mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
            mstatus[MSTATUS_MPIE] <= 1'b1;
        end else if (wr_en_i) begin
            // only the writable registers are decoded here.
            case (wr_addr_i)
                `CSR_MSTATUS: mstatus <= wr_data_i;
                `CSR_MTVEC:   mtvec   <= {wr_data_i[31:2], 2'b00};
                `CSR_MEPC:    mepc    <= wr_data_i;
                `CSR_MCAUSE:  mcause  <= wr_data_i;
                default:      mstatus <= mstatus;
            endcase
        end
    end

    // the identity registers are fixed values.
    always_comb begin
        rd_data_o     = '0;
        rd_known_o    = 1'b1;
        rd_writable_o = 1'b1;
        case (rd_addr_i)
            `CSR_MSTATUS: rd_data_o = mstatus;
            `CSR_MTVEC:   rd_data_o = mtvec;
            `CSR_MEPC:    rd_data_o = mepc;
            `CSR_MCAUSE:  rd_data_o = mcause;
            `CSR_MVENDORID: begin
                rd_data_o     = `CSR_VENDOR_ID;
                rd_writable_o = 1'b0;
            end
            `CSR_MARCHID: begin
                rd_data_o     = `CSR_ARCH_ID;
                rd_writable_o = 1'b0;
            end
            default: begin
                rd_known_o    = 1'b0;
                rd_writable_o = 1'b0;
            end
        endcase
    end

    // the trap target and the return address feed the redirect directly.
    assign mtvec_o = mtvec;
    assign mepc_o  = mepc;

endmodule

//--- logic/csr_req_queue.sv
`include "csr_cfg.svh"

module csr_req_queue (
    input  logic             clock,
    input  logic             reset,
    input  logic             req_valid_i,
    input  csr_pkg::csr_op_t req_op_i,
    input  logic [11:0]      req_addr_i,
    input  logic [31:0]      req_wdata_i,
    input  logic [31:0]      req_pc_i,
    input  logic             pop_i,
    output logic             valid_o,
    output csr_pkg::csr_op_t op_o,
    output logic [11:0]      addr_o,
    output logic [31:0]      wdata_o,
    output logic [31:0]      pc_o,
    output logic             credit_o
);
    import csr_pkg::*;

    localparam int PTR_W = (`REQ_DEPTH > 1) ? $clog2(`REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(`REQ_DEPTH + 1);

    csr_op_t     op_mem    [`REQ_DEPTH];
    logic [11:0] addr_mem  [`REQ_DEPTH];
    logic [31:0] wdata_mem [`REQ_DEPTH];
    logic [31:0] pc_mem    [`REQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // the core only sends with credit, so a full queue never sees a push.
    assign push = req_valid_i && (count != CNT_W'(`REQ_DEPTH));
    assign pop  = pop_i && valid_o;

    assign valid_o = (count != '0);
    assign op_o    = op_mem[rd_ptr];
    assign addr_o  = addr_mem[rd_ptr];
    assign wdata_o = wdata_mem[rd_ptr];
    assign pc_o    = pc_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            op_mem[wr_ptr]    <= req_op_i;
            addr_mem[wr_ptr]  <= req_addr_i;
            wdata_mem[wr_ptr] <= req_wdata_i;
            pc_mem[wr_ptr]    <= req_pc_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit goes back to the core for every entry that leaves.
            credit_o <= pop;
        end
    end

endmodule

//--- logic/csr_pkg.sv
package csr_pkg;

    // operations the core can issue to the machine CSR subsystem.
    // the immediate forms are folded into the register forms by the core.
    typedef enum logic [2:0] {
        CSR_RW    = 3'd0,
        CSR_RS    = 3'd1,
        CSR_RC    = 3'd2,
        CSR_ECALL = 3'd3,
        CSR_MRET  = 3'd4
    } csr_op_t;

    // machine interrupt enable and its previous value saved on trap entry.
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

endpackage

//--- logic/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// machine CSR addresses.
`define CSR_MSTATUS   12'h300
`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12

// values of the read-only identity registers.
`define CSR_VENDOR_ID 32'h7973_7978
`define CSR_ARCH_ID   32'd22060008

// environment call from machine mode.
`define ECALL_CAUSE   32'd11

// request queue depth, equal to the core's request credits after reset.
`define REQ_DEPTH     4

// response credits granted by the core after reset.
`define RSP_CREDITS   2

`endif
